//--- include/ppc_settings.svh
////////////////////////////////////////////////////////////////////////////
// Ping-pong controller sizes
// Bank count, block and column counts, RAM address width
////////////////////////////////////////////////////////////////////////////

`ifndef PPC_SETTINGS_SVH
`define PPC_SETTINGS_SVH

// Inner blocks per output element, also depth of one west half
`define PPC_BLOCKS 4

// Output columns per tile
`define PPC_COL_Y 2

// North depth, blocks times columns
`define PPC_N_DEPTH 8

// RAM address width, must cover 2*PPC_BLOCKS and PPC_N_DEPTH
`define PPC_ADDR_W 4

// Ping and pong
`define PPC_NUM_BANKS 2

`endif

//--- hw/ppc_buf_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Buffer RAM port types
// Port bundles for the west and north RAMs of one bank
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ppc_settings.svh"

package ppc_buf_pkg;

    // Read/write RAM port
    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [`PPC_ADDR_W-1:0] addr;
    } bram_wr_port_t;

    // Read-only RAM port
    typedef struct packed {
        logic                   en;
        logic [`PPC_ADDR_W-1:0] addr;
    } bram_rd_port_t;

    // West RAM, both ports written together
    // Port A holds the even half, port B the odd half
    typedef struct packed {
        bram_wr_port_t a;
        bram_wr_port_t b;
    } west_bank_t;

    // North RAM, written on A and read on B
    typedef struct packed {
        bram_wr_port_t a;
        bram_rd_port_t b;
    } north_bank_t;

    // All RAM ports of one bank
    typedef struct packed {
        west_bank_t  west;
        north_bank_t north;
    } bank_ports_t;

endpackage

`default_nettype wire

//--- hw/ppc_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Ping-pong control types
// Commands from the sequencer, status back from each bank, bank roles
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package ppc_ctrl_pkg;

    // Strobes to one bank, already gated by that bank's role
    typedef struct packed {
        // Clears the write counters
        logic wr_start;
        // One accepted input beat
        logic wr_beat;
        // Clears the read counters and the done flag
        logic rd_start;
        // Array finish pulse
        logic rd_step;
        // Rising edge of accumulator done
        logic rd_col;
    } bank_cmd_t;

    // Levels from one bank
    typedef struct packed {
        // All north entries written
        logic wr_full;
        // Last column of the tile consumed
        logic rd_done;
    } bank_stat_t;

    // Role of a bank in the current round
    typedef enum logic {
        WRITING = 1'b0,
        READING = 1'b1
    } bank_role_t;

endpackage

`default_nettype wire

//--- hw/bank_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Bank sequencer
// Keeps the bank roles, swaps them when a round ends and routes strobes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ppc_settings.svh"

module bank_sequencer (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              in_valid,
    input  logic                                              systolic_finish,
    input  logic                                              acc_done,
    input  ppc_ctrl_pkg::bank_stat_t [`PPC_NUM_BANKS-1:0]     stat,
    output ppc_ctrl_pkg::bank_cmd_t  [`PPC_NUM_BANKS-1:0]     cmd,
    output ppc_ctrl_pkg::bank_role_t [`PPC_NUM_BANKS-1:0]     role,
    output logic                                              tile_end
);
    import ppc_ctrl_pkg::*;

    localparam int NUM_BANKS = `PPC_NUM_BANKS;

    logic acc_done_q;
    logic acc_rise;
    logic start_q;
    logic writer_full;
    logic reader_done;
    logic reader_done_q;
    logic swap;
    logic live;

    // Status of whichever bank holds each role
    always_comb begin
        writer_full = 1'b0;
        reader_done = 1'b0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (role[i] == WRITING) begin
                writer_full = stat[i].wr_full;
            end else begin
                reader_done = stat[i].rd_done;
            end
        end
    end

    // No second swap while the start pulses are out
    assign swap     = writer_full & reader_done & ~start_q;
    assign live     = ~start_q;
    assign acc_rise = acc_done & ~acc_done_q;
    // First cycle the reader reports done
    assign tile_end = reader_done & ~reader_done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Bank 0 fills first, bank 1 counts as already read
            for (int i = 0; i < NUM_BANKS; i++) begin
                role[i] <= (i == 0) ? WRITING : READING;
            end
            start_q       <= 1'b0;
            acc_done_q    <= 1'b0;
            reader_done_q <= 1'b1;
        end else begin
            if (swap) begin
                for (int i = 0; i < NUM_BANKS; i++) begin
                    role[i] <= (role[i] == WRITING) ? READING : WRITING;
                end
            end
            start_q       <= swap;
            acc_done_q    <= acc_done;
            reader_done_q <= reader_done;
        end
    end

    // Strobes reach only the bank in the matching role
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            cmd[i].wr_start = start_q & (role[i] == WRITING);
            cmd[i].rd_start = start_q & (role[i] == READING);
            // Beats to a full writer are dropped here
            cmd[i].wr_beat  = in_valid & live & (role[i] == WRITING) & ~stat[i].wr_full;
            cmd[i].rd_step  = systolic_finish & live & (role[i] == READING);
            cmd[i].rd_col   = acc_rise & live & (role[i] == READING);
        end
    end

endmodule

`default_nettype wire

//--- hw/bank_addr_gen.sv
////////////////////////////////////////////////////////////////////////////
// Bank address generator
// Write and read counters of one bank, and its RAM port values
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ppc_settings.svh"

module bank_addr_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ppc_ctrl_pkg::bank_cmd_t  cmd,
    output ppc_ctrl_pkg::bank_stat_t stat,
    output ppc_buf_pkg::bank_ports_t ports
);
    localparam int BLOCKS  = `PPC_BLOCKS;
    localparam int COL_Y   = `PPC_COL_Y;
    localparam int N_DEPTH = `PPC_N_DEPTH;
    localparam int ADDR_W  = `PPC_ADDR_W;
    localparam int WEST_W  = $clog2(BLOCKS + 1);
    localparam int NORTH_W = $clog2(N_DEPTH + 1);
    localparam int BLK_W   = (BLOCKS > 1) ? $clog2(BLOCKS) : 1;
    localparam int COL_W   = (COL_Y > 1) ? $clog2(COL_Y) : 1;

    // Write side, saturating counts of accepted beats
    logic [WEST_W-1:0]  west_cnt;
    logic [NORTH_W-1:0] north_cnt;
    // Read side
    logic [BLK_W-1:0]   blk_cnt;
    logic [COL_W-1:0]   col_cnt;
    logic               rd_done;

    logic               west_open;
    logic               west_wr;
    logic [ADDR_W-1:0]  west_a_rd;
    logic [ADDR_W-1:0]  west_b_rd;
    logic [ADDR_W-1:0]  north_b_rd;

    // Last address driven on each port
    logic [ADDR_W-1:0]  west_a_hold;
    logic [ADDR_W-1:0]  west_b_hold;
    logic [ADDR_W-1:0]  north_a_hold;
    logic [ADDR_W-1:0]  north_b_hold;

    // West takes only the first BLOCKS beats
    assign west_open = (west_cnt != WEST_W'(BLOCKS));
    assign west_wr   = cmd.wr_beat & west_open;

    // Read addresses from block and column
    assign west_a_rd  = ADDR_W'(blk_cnt);
    assign west_b_rd  = ADDR_W'(BLOCKS) + ADDR_W'(blk_cnt);
    assign north_b_rd = ADDR_W'(BLOCKS * col_cnt) + ADDR_W'(blk_cnt);

    assign stat.wr_full = (north_cnt == NORTH_W'(N_DEPTH));
    assign stat.rd_done = rd_done;

    always_comb begin
        // RAMs stay enabled, reset is applied at the port register
        ports.west.a.en  = 1'b1;
        ports.west.b.en  = 1'b1;
        ports.north.a.en = 1'b1;
        ports.north.b.en = 1'b1;

        ports.west.a.we  = west_wr;
        ports.west.b.we  = west_wr;
        ports.north.a.we = cmd.wr_beat;

        // West ports are shared by the write and read sides
        if (west_wr) begin
            ports.west.a.addr = ADDR_W'(west_cnt);
            ports.west.b.addr = ADDR_W'(BLOCKS) + ADDR_W'(west_cnt);
        end else if (cmd.rd_step) begin
            ports.west.a.addr = west_a_rd;
            ports.west.b.addr = west_b_rd;
        end else begin
            ports.west.a.addr = west_a_hold;
            ports.west.b.addr = west_b_hold;
        end

        ports.north.a.addr = cmd.wr_beat ? ADDR_W'(north_cnt) : north_a_hold;
        ports.north.b.addr = cmd.rd_step ? north_b_rd : north_b_hold;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            west_cnt     <= '0;
            north_cnt    <= '0;
            blk_cnt      <= '0;
            col_cnt      <= '0;
            // A fresh bank has nothing left to read
            rd_done      <= 1'b1;
            west_a_hold  <= '0;
            west_b_hold  <= ADDR_W'(BLOCKS);
            north_a_hold <= '0;
            north_b_hold <= '0;
        end else begin
            west_a_hold  <= ports.west.a.addr;
            west_b_hold  <= ports.west.b.addr;
            north_a_hold <= ports.north.a.addr;
            north_b_hold <= ports.north.b.addr;

            if (cmd.wr_start) begin
                west_cnt  <= '0;
                north_cnt <= '0;
            end else if (cmd.wr_beat) begin
                north_cnt <= north_cnt + 1'b1;
                if (west_open) begin
                    west_cnt <= west_cnt + 1'b1;
                end
            end

            if (cmd.rd_start) begin
                blk_cnt <= '0;
                col_cnt <= '0;
                rd_done <= 1'b0;
            end else begin
                // Block count wraps once per output element
                if (cmd.rd_step) begin
                    if (blk_cnt == BLK_W'(BLOCKS - 1)) begin
                        blk_cnt <= '0;
                    end else begin
                        blk_cnt <= blk_cnt + 1'b1;
                    end
                end
                // Done after the last column of the tile
                if (cmd.rd_col) begin
                    if (col_cnt == COL_W'(COL_Y - 1)) begin
                        col_cnt <= '0;
                        rd_done <= 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/bank_port_register.sv
////////////////////////////////////////////////////////////////////////////
// Bank port register
// Output flops for all RAM ports, plus ready, active and tile status
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ppc_settings.svh"

module bank_port_register (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  ppc_buf_pkg::bank_ports_t [`PPC_NUM_BANKS-1:0]     ports_in,
    input  ppc_ctrl_pkg::bank_role_t [`PPC_NUM_BANKS-1:0]     role,
    input  logic                                              tile_end,
    output ppc_buf_pkg::bank_ports_t [`PPC_NUM_BANKS-1:0]     bank_ports,
    output logic                                              write_ready,
    output logic                                              read_active,
    output logic                                              tile_done
);
    import ppc_ctrl_pkg::*;

    localparam int NUM_BANKS = `PPC_NUM_BANKS;
    localparam int N_DEPTH   = `PPC_N_DEPTH;
    localparam int ADDR_W    = `PPC_ADDR_W;

    bank_role_t [NUM_BANKS-1:0] role_q;
    logic                       role_changed;
    logic                       last_write;

    // Roles just swapped, a new round starts
    assign role_changed = (role != role_q);

    // Writer takes its last north entry
    always_comb begin
        last_write = 1'b0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if ((role[i] == WRITING) && ports_in[i].north.a.we &&
                (ports_in[i].north.a.addr == ADDR_W'(N_DEPTH - 1))) begin
                last_write = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // All enables low in reset
            bank_ports  <= '0;
            for (int i = 0; i < NUM_BANKS; i++) begin
                role_q[i] <= (i == 0) ? WRITING : READING;
            end
            write_ready <= 1'b1;
            read_active <= 1'b0;
            tile_done   <= 1'b0;
        end else begin
            bank_ports <= ports_in;
            role_q     <= role;
            tile_done  <= tile_end;
            if (role_changed) begin
                write_ready <= 1'b1;
                read_active <= 1'b1;
            end else begin
                // Held low until the reader finishes and the roles swap
                if (last_write) begin
                    write_ready <= 1'b0;
                end
                if (tile_end) begin
                    read_active <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/ping_pong_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Ping-pong buffer address controller
// Sequencer, one address generator per bank, output port register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ppc_settings.svh"

module ping_pong_ctrl (
    input  logic                                              clk,
    input  logic                                              rst_n,
    // Input beat strobe
    input  logic                                              in_valid,
    // One-cycle pulse per array pass
    input  logic                                              systolic_finish,
    // Accumulator done level
    input  logic                                              acc_done,
    output ppc_buf_pkg::bank_ports_t [`PPC_NUM_BANKS-1:0]     bank_ports,
    output logic                                              write_ready,
    output logic                                              read_active,
    output logic                                              tile_done
);
    import ppc_buf_pkg::*;
    import ppc_ctrl_pkg::*;

    localparam int NUM_BANKS = `PPC_NUM_BANKS;

    bank_cmd_t   [NUM_BANKS-1:0] cmd;
    bank_stat_t  [NUM_BANKS-1:0] stat;
    bank_role_t  [NUM_BANKS-1:0] role;
    bank_ports_t [NUM_BANKS-1:0] ports;
    logic                        tile_end;

    bank_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .systolic_finish (systolic_finish),
        .acc_done        (acc_done),
        .stat            (stat),
        .cmd             (cmd),
        .role            (role),
        .tile_end        (tile_end)
    );

    // Identical generators, one per bank
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        bank_addr_gen u_addr_gen (
            .clk   (clk),
            .rst_n (rst_n),
            .cmd   (cmd[i]),
            .stat  (stat[i]),
            .ports (ports[i])
        );
    end

    bank_port_register u_port_register (
        .clk         (clk),
        .rst_n       (rst_n),
        .ports_in    (ports),
        .role        (role),
        .tile_end    (tile_end),
        .bank_ports  (bank_ports),
        .write_ready (write_ready),
        .read_active (read_active),
        .tile_done   (tile_done)
    );

endmodule

`default_nettype wire

//--- bench/tb_ping_pong_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Ping-pong controller testbench
// Directed tests for fill, swap, read addressing and back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ppc_settings.svh"

module tb_ping_pong_ctrl;
    import ppc_buf_pkg::*;

    localparam int NUM_BANKS = `PPC_NUM_BANKS;
    localparam int BLOCKS    = `PPC_BLOCKS;
    localparam int COL_Y     = `PPC_COL_Y;
    localparam int N_DEPTH   = `PPC_N_DEPTH;
    localparam int ADDR_W    = `PPC_ADDR_W;
    // Beats and steps over all tests, acc_done pulses counted as steps
    localparam int TOTAL_BEATS = 2 * N_DEPTH + 8;
    localparam int TOTAL_STEPS = BLOCKS * COL_Y + 8 * COL_Y + 2;
    // Generous cycle budget per beat or step
    localparam int WATCHDOG_CYCLES = 16 * (TOTAL_BEATS + TOTAL_STEPS) + 40;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic                        systolic_finish;
    logic                        acc_done;
    bank_ports_t [NUM_BANKS-1:0] bank_ports;
    logic                        write_ready;
    logic                        read_active;
    logic                        tile_done;

    logic [31:0] lfsr;
    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;
    // Error count when the current test began
    int          test_errors;

    ping_pong_ctrl u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .systolic_finish (systolic_finish),
        .acc_done        (acc_done),
        .bank_ports      (bank_ports),
        .write_ready     (write_ready),
        .read_active     (read_active),
        .tile_done       (tile_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic compare_wr_port(input string name, input bram_wr_port_t got,
                                   input bram_wr_port_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic compare_rd_port(input string name, input bram_rd_port_t got,
                                   input bram_rd_port_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    // Anything that is not a wrong value
    task automatic report_problem(input string msg);
        error_count++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic begin_test();
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, error_count - test_errors);
        end
    endtask

    // No write enable on any bank
    task automatic check_no_writes();
        for (int b = 0; b < NUM_BANKS; b++) begin
            compare_bit($sformatf("bank%0d west.a.we", b), bank_ports[b].west.a.we, 1'b0);
            compare_bit($sformatf("bank%0d west.b.we", b), bank_ports[b].west.b.we, 1'b0);
            compare_bit($sformatf("bank%0d north.a.we", b), bank_ports[b].north.a.we, 1'b0);
        end
    endtask

    task automatic check_enables(input logic want);
        for (int b = 0; b < NUM_BANKS; b++) begin
            compare_bit($sformatf("bank%0d west.a.en", b), bank_ports[b].west.a.en, want);
            compare_bit($sformatf("bank%0d west.b.en", b), bank_ports[b].west.b.en, want);
            compare_bit($sformatf("bank%0d north.a.en", b), bank_ports[b].north.a.en, want);
            compare_bit($sformatf("bank%0d north.b.en", b), bank_ports[b].north.b.en, want);
        end
        check_no_writes();
    endtask

    // Every task below returns just after a falling edge
    task automatic idle_cycle();
        @(posedge clk);
        @(negedge clk);
        check_no_writes();
    endtask

    task automatic wait_write_ready();
        int cycles;
        cycles = 0;
        while (write_ready !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (write_ready !== 1'b1) begin
            report_problem("write_ready stayed low too long");
        end
    endtask

    // Roles swap, reader comes up
    task automatic wait_for_swap();
        int cycles;
        cycles = 0;
        while (read_active !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            check_no_writes();
            cycles++;
        end
        if (read_active !== 1'b1) begin
            report_problem("read_active never rose, the banks did not swap");
        end
    endtask

    // One beat, expected to land at entry idx of the writing bank
    task automatic send_beat(input int bank, input int idx);
        bram_wr_port_t want;
        @(posedge clk);
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        want.en   = 1'b1;
        want.we   = 1'b1;
        want.addr = ADDR_W'(idx);
        compare_wr_port($sformatf("bank%0d north.a", bank), bank_ports[bank].north.a, want);
        // West takes only the first BLOCKS beats, both halves at once
        if (idx < BLOCKS) begin
            compare_wr_port($sformatf("bank%0d west.a", bank), bank_ports[bank].west.a, want);
            want.addr = ADDR_W'(BLOCKS + idx);
            compare_wr_port($sformatf("bank%0d west.b", bank), bank_ports[bank].west.b, want);
        end else begin
            compare_bit($sformatf("bank%0d west.a.we", bank), bank_ports[bank].west.a.we, 1'b0);
            compare_bit($sformatf("bank%0d west.b.we", bank), bank_ports[bank].west.b.we, 1'b0);
        end
        compare_bit($sformatf("bank%0d north.a.we", 1 - bank),
                    bank_ports[1 - bank].north.a.we, 1'b0);
    endtask

    // Beats with random idle gaps of 0 to 3 cycles
    task automatic fill_beats(input int bank, input int first, input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = take_bits(2);
            repeat (gap) idle_cycle();
            wait_write_ready();
            send_beat(bank, first + i);
        end
    endtask

    // Finish pulse, read addresses from block and column
    task automatic send_step(input int bank, input int col, input int blk);
        bram_wr_port_t want_w;
        bram_rd_port_t want_n;
        @(posedge clk);
        systolic_finish <= 1'b1;
        @(posedge clk);
        systolic_finish <= 1'b0;
        @(negedge clk);
        want_w.en   = 1'b1;
        want_w.we   = 1'b0;
        want_w.addr = ADDR_W'(blk);
        compare_wr_port($sformatf("bank%0d west.a", bank), bank_ports[bank].west.a, want_w);
        want_w.addr = ADDR_W'(BLOCKS + blk);
        compare_wr_port($sformatf("bank%0d west.b", bank), bank_ports[bank].west.b, want_w);
        want_n.en   = 1'b1;
        want_n.addr = ADDR_W'(BLOCKS * col + blk);
        compare_rd_port($sformatf("bank%0d north.b", bank), bank_ports[bank].north.b, want_n);
    endtask

    // Accumulator done held high three cycles, tile_done pulses counted
    task automatic pulse_acc_done(input int expected);
        int pulses;
        pulses = 0;
        @(posedge clk);
        acc_done <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (tile_done === 1'b1) begin
                pulses++;
            end
            @(posedge clk);
            if (i == 2) begin
                acc_done <= 1'b0;
            end
        end
        @(negedge clk);
        if (pulses != expected) begin
            report_problem($sformatf("tile_done pulsed %0d times, expected %0d",
                                     pulses, expected));
        end
    endtask

    task automatic test_reset();
        begin_test();
        @(posedge clk);
        @(negedge clk);
        check_enables(1'b0);
        // Second reset edge, then the first edge out of reset
        @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_enables(1'b1);
        compare_bit("write_ready", write_ready, 1'b1);
        compare_bit("read_active", read_active, 1'b0);
        compare_bit("tile_done", tile_done, 1'b0);
        end_test("reset");
    endtask

    task automatic test_fill_first_bank();
        begin_test();
        fill_beats(0, 0, N_DEPTH);
        compare_bit("write_ready", write_ready, 1'b0);
        end_test("fill bank 0");
    endtask

    task automatic test_swap();
        begin_test();
        wait_for_swap();
        compare_bit("write_ready", write_ready, 1'b1);
        // Bank 1 now writes from entry 0
        send_beat(1, 0);
        send_beat(1, 1);
        end_test("swap");
    endtask

    task automatic test_back_pressure();
        begin_test();
        fill_beats(1, 2, N_DEPTH - 2);
        compare_bit("write_ready", write_ready, 1'b0);
        // Extra beats to a full writer are dropped
        repeat (3) begin
            @(posedge clk);
            in_valid <= 1'b1;
            @(posedge clk);
            in_valid <= 1'b0;
            @(negedge clk);
            check_no_writes();
            compare_bit("write_ready", write_ready, 1'b0);
            compare_bit("read_active", read_active, 1'b1);
        end
        end_test("back-pressure");
    endtask

    task automatic test_read_addressing();
        begin_test();
        for (int col = 0; col < COL_Y; col++) begin
            for (int blk = 0; blk < BLOCKS; blk++) begin
                send_step(0, col, blk);
                idle_cycle();
            end
            // Tile ends only after the last column
            pulse_acc_done((col == COL_Y - 1) ? 1 : 0);
        end
        end_test("read addressing");
    endtask

    task automatic test_second_round();
        begin_test();
        wait_for_swap();
        compare_bit("write_ready", write_ready, 1'b1);
        send_beat(0, 0);
        send_beat(0, 1);
        // Bank 1 reads from block 0, column 0
        send_step(1, 0, 0);
        send_step(1, 0, 1);
        end_test("second round");
    endtask

    initial begin
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        systolic_finish = 1'b0;
        acc_done        = 1'b0;
        lfsr            = 32'hd476575f;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        failed_tests    = 0;
        test_errors     = 0;

        test_reset();
        test_fill_first_bank();
        test_swap();
        test_back_pressure();
        test_read_addressing();
        test_second_round();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Ends a run that stalls
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hw/ppc_buf_pkg.sv
hw/ppc_ctrl_pkg.sv
hw/bank_sequencer.sv
hw/bank_addr_gen.sv
hw/bank_port_register.sv
hw/ping_pong_ctrl.sv
bench/tb_ping_pong_ctrl.sv

//--- Makefile
# Verilator flow for the ping-pong controller testbench

TOOL       = verilator
FLAGS      = --binary --timing --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP        = tb_ping_pong_ctrl
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = ALL TESTS PASSED

.PHONY: lint build sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

# The log decides pass or fail
sim: build
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
